/* cdc_pkg.sv */
package cdc_pkg;

    // ==================================================
    // Widths and FIFO geometry
    // ==================================================

    // Sample payload and sequence tag widths
    localparam int DATA_W = 8;
    localparam int SEQ_W  = 4;

    // Address bits of the FIFO memory
    localparam int ADDR_W = 4;
    localparam int DEPTH  = 1 << ADDR_W;

    // Occupancy thresholds for the almost flags
    localparam int ALMOST_FULL_LVL  = 12;
    localparam int ALMOST_EMPTY_LVL = 4;

    // ==================================================
    // Types
    // ==================================================

    typedef logic [DATA_W-1:0] sample_t;
    typedef logic [SEQ_W-1:0]  seq_t;

    // Pointer holds one extra wrap bit above the address
    typedef logic [ADDR_W:0]   ptr_t;

    // Word stored in the FIFO memory, tag in the upper bits
    typedef struct packed {
        seq_t    seq;
        sample_t data;
    } fifo_word_t;

endpackage

/* sample_framer.sv */
`timescale 1ns/10ps

module sample_framer (
    input  logic                w_clk,
    input  logic                r_rstn,
    input  logic                in_valid,
    input  cdc_pkg::sample_t    in_sample,
    output logic                wr_en,
    output cdc_pkg::fifo_word_t wr_word
);
    import cdc_pkg::*;

    // Tag for the next accepted input strobe
    seq_t seq_cnt;

    // ==================================================
    // Control path
    // ==================================================

    // The tag advances on every strobe, so anything the
    // FIFO drops later shows up as a jump in the tags
    always_ff @(posedge w_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            wr_en   <= 1'b0;
            seq_cnt <= '0;
        end else begin
            wr_en <= in_valid;
            if (in_valid) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Payload register
    // ==================================================

    // Only loaded on a strobe, qualified downstream by wr_en
    always_ff @(posedge w_clk) begin
        if (in_valid) begin
            wr_word.seq  <= seq_cnt;
            wr_word.data <= in_sample;
        end
    end

endmodule

/* cdc_async_fifo.sv */
`timescale 1ns/10ps

module cdc_async_fifo (
    input  logic                w_clk,
    input  logic                r_clk,
    input  logic                r_rstn,
    input  logic                wr_en,
    input  cdc_pkg::fifo_word_t wr_word,
    input  logic                rd_en,
    output logic                full,
    output logic                almost_full,
    output logic                almost_empty,
    output logic                rd_valid,
    output cdc_pkg::fifo_word_t rd_word
);
    import cdc_pkg::*;

    // Dual-port storage, no reset on the array
    fifo_word_t mem [DEPTH];

    // Write domain
    ptr_t wbin;
    ptr_t wgray;
    ptr_t wq1_rgray;
    ptr_t wq2_rgray;
    ptr_t wbin_next;
    ptr_t wgray_next;
    ptr_t wq2_rbin;
    ptr_t w_level;
    logic wr_fire;

    // Read domain
    ptr_t rbin;
    ptr_t rgray;
    ptr_t rq1_wgray;
    ptr_t rq2_wgray;
    ptr_t rbin_next;
    ptr_t rgray_next;
    ptr_t rq2_wbin;
    ptr_t r_level;
    logic rd_fire;
    logic empty;

    // Gray to binary, MSB passes straight through
    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[ADDR_W] = g[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ==================================================
    // Write domain
    // ==================================================

    assign wr_fire    = wr_en && !full;
    assign wbin_next  = wbin + ptr_t'(wr_fire);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;
    assign wq2_rbin   = gray2bin(wq2_rgray);

    // Occupancy wraps naturally in the extra pointer bit
    assign w_level = wbin_next - wq2_rbin;

    always_ff @(posedge w_clk) begin
        if (wr_fire) begin
            mem[wbin[ADDR_W-1:0]] <= wr_word;
        end
    end

    // Two-flop synchronizer for the read pointer
    always_ff @(posedge w_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= rgray;
            wq2_rgray <= wq1_rgray;
        end
    end

    // Full when next Gray pointer differs only in the top two bits
    always_ff @(posedge w_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            wbin        <= '0;
            wgray       <= '0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            wbin        <= wbin_next;
            wgray       <= wgray_next;
            full        <= (wgray_next == {~wq2_rgray[ADDR_W:ADDR_W-1],
                                           wq2_rgray[ADDR_W-2:0]});
            almost_full <= (w_level >= ptr_t'(ALMOST_FULL_LVL));
        end
    end

    // ==================================================
    // Read domain
    // ==================================================

    assign rd_fire    = rd_en && !empty;
    assign rbin_next  = rbin + ptr_t'(rd_fire);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;
    assign rq2_wbin   = gray2bin(rq2_wgray);
    assign r_level    = rq2_wbin - rbin_next;

    // Two-flop synchronizer for the write pointer
    always_ff @(posedge r_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= wgray;
            rq2_wgray <= rq1_wgray;
        end
    end

    always_ff @(posedge r_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            rbin         <= '0;
            rgray        <= '0;
            empty        <= 1'b1;
            almost_empty <= 1'b1;
            rd_valid     <= 1'b0;
        end else begin
            rbin         <= rbin_next;
            rgray        <= rgray_next;
            empty        <= (rgray_next == rq2_wgray);
            almost_empty <= (r_level <= ptr_t'(ALMOST_EMPTY_LVL));
            rd_valid     <= rd_fire;
        end
    end

    // Read data registered, valid for one cycle with rd_valid
    always_ff @(posedge r_clk) begin
        if (rd_fire) begin
            rd_word <= mem[rbin[ADDR_W-1:0]];
        end
    end

endmodule

/* sample_deframer.sv */
`timescale 1ns/10ps

module sample_deframer (
    input  logic                r_clk,
    input  logic                r_rstn,
    input  logic                drain,
    input  logic                rd_valid,
    input  cdc_pkg::fifo_word_t rd_word,
    output logic                rd_en,
    output logic                out_valid,
    output cdc_pkg::sample_t    out_sample,
    output cdc_pkg::seq_t       out_seq,
    output logic                out_gap,
    output logic [15:0]         lost_count
);
    import cdc_pkg::*;

    // Tag expected on the next delivered word
    seq_t exp_seq;
    // Samples skipped between expected and received tag
    seq_t seq_diff;
    logic seq_miss;

    // Read every cycle while drain is high, FIFO guards empty
    assign rd_en = drain;

    assign seq_diff = rd_word.seq - exp_seq;
    assign seq_miss = (rd_word.seq != exp_seq);

    // ==================================================
    // Continuity check
    // ==================================================

    // A gap of 16 or more aliases modulo 16
    always_ff @(posedge r_clk or negedge r_rstn) begin
        if (!r_rstn) begin
            out_valid  <= 1'b0;
            out_gap    <= 1'b0;
            exp_seq    <= '0;
            lost_count <= '0;
        end else begin
            out_valid <= rd_valid;
            out_gap   <= rd_valid && seq_miss;
            if (rd_valid) begin
                exp_seq    <= rd_word.seq + 1'b1;
                lost_count <= lost_count + {{(16-SEQ_W){1'b0}}, seq_diff};
            end
        end
    end

    // ==================================================
    // Output payload
    // ==================================================

    always_ff @(posedge r_clk) begin
        if (rd_valid) begin
            out_sample <= rd_word.data;
            out_seq    <= rd_word.seq;
        end
    end

endmodule

/* cdc_bridge_top.sv */
`timescale 1ns/10ps

module cdc_bridge_top (
    input  logic             w_clk,
    input  logic             r_clk,
    input  logic             r_rstn,
    input  logic             in_valid,
    input  cdc_pkg::sample_t in_sample,
    input  logic             drain,
    output logic             full,
    output logic             almost_full,
    output logic             almost_empty,
    output logic             out_valid,
    output cdc_pkg::sample_t out_sample,
    output cdc_pkg::seq_t    out_seq,
    output logic             out_gap,
    output logic [15:0]      lost_count
);
    import cdc_pkg::*;

    // Write side, framer into FIFO
    logic       wr_en;
    fifo_word_t wr_word;

    // Read side, FIFO into deframer
    logic       rd_en;
    logic       rd_valid;
    fifo_word_t rd_word;

    // ==================================================
    // Producer, buffer, consumer
    // ==================================================

    sample_framer u_framer (
        .w_clk     (w_clk),
        .r_rstn    (r_rstn),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .wr_en     (wr_en),
        .wr_word   (wr_word)
    );

    cdc_async_fifo u_fifo (
        .w_clk        (w_clk),
        .r_clk        (r_clk),
        .r_rstn       (r_rstn),
        .wr_en        (wr_en),
        .wr_word      (wr_word),
        .rd_en        (rd_en),
        .full         (full),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .rd_valid     (rd_valid),
        .rd_word      (rd_word)
    );

    sample_deframer u_deframer (
        .r_clk      (r_clk),
        .r_rstn     (r_rstn),
        .drain      (drain),
        .rd_valid   (rd_valid),
        .rd_word    (rd_word),
        .rd_en      (rd_en),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_seq    (out_seq),
        .out_gap    (out_gap),
        .lost_count (lost_count)
    );

endmodule

/* tb_cdc_bridge.sv */
`timescale 1ns/10ps

module tb_cdc_bridge;
    import cdc_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;

    logic        w_clk = 1'b0;
    logic        r_clk = 1'b0;
    logic        r_rstn = 1'b0;
    logic        in_valid = 1'b0;
    sample_t     in_sample = '0;
    logic        drain = 1'b0;
    logic        full;
    logic        almost_full;
    logic        almost_empty;
    logic        out_valid;
    sample_t     out_sample;
    seq_t        out_seq;
    logic        out_gap;
    logic [15:0] lost_count;

    // Reference model of the stored words in FIFO order
    fifo_word_t  exp_q[$];
    fifo_word_t  head;
    seq_t        exp_tag = '0;
    logic [15:0] model_lost = '0;
    logic        last_gap = 1'b0;
    int          in_count = 0;
    int          deliveries = 0;
    int          errors = 0;
    int          cycle_count = 0;
    int          base_count;
    logic [15:0] base_lost;
    logic [31:0] w_rng = 32'h599487e8;
    logic [31:0] r_rng = 32'h599487e8;
    logic        drain_req = 1'b0;
    logic        rand_drain = 1'b0;
    logic        af_gate = 1'b0;

    always #20 w_clk = ~w_clk;
    always #28 r_clk = ~r_clk;

    cdc_bridge_top uut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int want);
        errors++;
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    endtask

    // A strobe seen while full is lost in the FIFO
    task automatic drive_cycle(input logic valid, input sample_t value);
        fifo_word_t entry;
        logic       send;
        @(posedge w_clk);
        send = valid && !(af_gate && almost_full);
        in_valid  <= send;
        in_sample <= value;
        if (send) begin
            entry.seq  = seq_t'(in_count);
            entry.data = value;
            if (!full) begin
                exp_q.push_back(entry);
            end
            in_count++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0);
    endtask

    task automatic write_burst(input int n);
        repeat (n) begin
            w_rng = lcg_next(w_rng);
            drive_cycle(1'b1, w_rng[23:16]);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge w_clk);
        end
        idle_cycles(10);
        @(negedge w_clk);
    endtask

    // Drain level comes from the sequence or from the LCG
    always @(posedge r_clk) begin
        if (rand_drain) begin
            r_rng = lcg_next(r_rng);
            drain <= r_rng[20];
        end else begin
            drain <= drain_req;
        end
    end

    always @(posedge w_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d w_clk cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ==================================================
    // Output checks
    // ==================================================

    assert property (@(negedge w_clk) disable iff (!r_rstn) full |-> almost_full)
        else report_mismatch("almost_full while full", almost_full, 1);
    assert property (@(negedge r_clk) disable iff (!r_rstn) out_gap |-> out_valid)
        else report_mismatch("out_valid with out_gap", out_valid, 1);

    // Outputs only move on posedge r_clk
    always @(negedge r_clk) begin
        if (r_rstn && out_valid) begin
            deliveries++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output sample at %0t ns with nothing left in the model", $time);
            end else begin
                head = exp_q.pop_front();
                model_lost = model_lost + 16'(seq_t'(head.seq - exp_tag));
                assert (out_seq == head.seq)
                    else report_mismatch("out_seq", out_seq, head.seq);
                assert (out_sample == head.data)
                    else report_mismatch("out_sample", out_sample, head.data);
                assert (out_gap == (head.seq != exp_tag))
                    else report_mismatch("out_gap", out_gap, head.seq != exp_tag);
                assert (lost_count == model_lost)
                    else report_mismatch("lost_count", lost_count, model_lost);
                exp_tag = head.seq + 1'b1;
                last_gap = out_gap;
            end
        end
    end

    // ==================================================
    // Sequence
    // ==================================================

    initial begin
        repeat (4) @(posedge w_clk);
        r_rstn <= 1'b1;
        @(negedge w_clk);
        assert (out_valid == 1'b0) else report_mismatch("out_valid", out_valid, 0);
        assert (full == 1'b0) else report_mismatch("full", full, 0);
        assert (almost_full == 1'b0) else report_mismatch("almost_full", almost_full, 0);
        assert (almost_empty == 1'b1) else report_mismatch("almost_empty", almost_empty, 1);
        assert (lost_count == 16'd0) else report_mismatch("lost_count", lost_count, 0);

        // Sparse samples with drain high
        drain_req <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            write_burst(1);
            idle_cycles(1 + int'(w_rng[2:0]));
        end
        wait_drained();

        // Fill up with drain low
        drain_req <= 1'b0;
        idle_cycles(4);
        write_burst(12);
        idle_cycles(10);
        @(negedge w_clk);
        assert (almost_full == 1'b1) else report_mismatch("almost_full", almost_full, 1);
        assert (full == 1'b0) else report_mismatch("full", full, 0);
        write_burst(4);
        idle_cycles(10);
        @(negedge w_clk);
        assert (full == 1'b1) else report_mismatch("full", full, 1);
        assert (almost_empty == 1'b0) else report_mismatch("almost_empty", almost_empty, 0);

        // Overflow by four and then drain
        base_count = deliveries;
        base_lost  = lost_count;
        write_burst(4);
        idle_cycles(10);
        drain_req <= 1'b1;
        wait_drained();
        assert (deliveries - base_count == 16)
            else report_mismatch("samples after overflow", deliveries - base_count, 16);
        write_burst(1);
        idle_cycles(1);
        wait_drained();
        assert (last_gap == 1'b1) else report_mismatch("out_gap after overflow", last_gap, 1);
        assert (lost_count == base_lost + 16'd4)
            else report_mismatch("lost_count after overflow", lost_count, base_lost + 4);

        // Random bursts held off by almost_full so nothing is dropped
        af_gate = 1'b1;
        rand_drain <= 1'b1;
        repeat (400) begin
            w_rng = lcg_next(w_rng);
            drive_cycle(w_rng[17:16] != 2'b00, w_rng[31:24]);
        end
        af_gate = 1'b0;
        rand_drain <= 1'b0;
        drain_req  <= 1'b1;
        wait_drained();
        assert (lost_count == 16'(in_count - deliveries))
            else report_mismatch("final lost_count", lost_count, in_count - deliveries);
        assert (almost_empty == 1'b1) else report_mismatch("almost_empty", almost_empty, 1);
        assert (almost_full == 1'b0) else report_mismatch("almost_full", almost_full, 0);

        $display("Inputs %0d, deliveries %0d, lost %0d, errors %0d",
                 in_count, deliveries, lost_count, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
cdc_pkg.sv
sample_framer.sv
cdc_async_fifo.sv
sample_deframer.sv
cdc_bridge_top.sv
tb_cdc_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CDC bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cdc_bridge -Mdir "$OBJ" -o tb_cdc_bridge -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_cdc_bridge" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0
